// File: io_pkg.sv
// Shared widths, register map and write-word layouts, used by the I/O subsystem RTL and testbench
`default_nettype none

package io_pkg;

    // Channel counts
    localparam int NUM_LEDS    = 18;
    localparam int NUM_SENSORS = 9;

    // Index widths for each array
    localparam int LED_IDX_W   = 5;  // 18 LEDs
    localparam int SENSE_IDX_W = 4;  // 9 pads

    // Register port
    localparam int ADDR_W    = 12;
    localparam int DATA_W    = 32;
    localparam int ADDR_LO_W = 5;   // Offset inside a 32-word block

    // Address map
    // LED commands sit at 0x000 to 0x011, one word per LED
    localparam logic [ADDR_W-1:0] LED_BASE   = 12'h000;
    // Per-pad discharge counts at 0x020 to 0x028, read only
    localparam logic [ADDR_W-1:0] SENSE_BASE = 12'h020;
    localparam logic [ADDR_W-1:0] TOUCH_ADDR = 12'h030;  // Touch mask, read only
    localparam logic [ADDR_W-1:0] CFG_ADDR   = 12'h031;  // Sensor config, read/write

    // Touch threshold out of reset
    localparam logic [15:0] RESET_THRESHOLD = 16'd40;

    // LED command word
    typedef struct packed {
        logic [22:0] unused;      // Kept as written, returned on readback
        logic        blink;       // Gate output with blink phase
        logic [7:0]  brightness;  // 0 is off, 255 is max duty
    } led_cmd_t;

    // Sensor configuration word
    typedef struct packed {
        logic [15:0] unused;
        logic [15:0] threshold;   // Count at or above this means touched
    } sense_cfg_t;

    // One write word seen two ways
    // LED block uses the led view, sensor block the cfg view
    typedef union packed {
        led_cmd_t   led;
        sense_cfg_t cfg;
    } io_word_u;

endpackage

`default_nettype wire

// File: periph_if.sv
// Decoded register access path between the bridge and one peripheral block
`default_nettype none
`timescale 1ns/1ns

interface periph_if;

    logic                              sel;      // Access targets this block
    logic                              wr;       // Write strobe
    logic                              rd;       // Read strobe
    logic [io_pkg::ADDR_LO_W-1:0]      addr_lo;  // Word offset in block
    io_pkg::io_word_u                  wdata;    // Write word, both views
    logic [io_pkg::DATA_W-1:0]         rdata;    // Read data, comb
    logic [io_pkg::NUM_SENSORS-1:0]    touch;    // Touch mask, sensor block only

    // Bridge side
    modport host (
        output sel, wr, rd, addr_lo, wdata,
        input  rdata, touch
    );

    // Peripheral side
    modport periph (
        input  sel, wr, rd, addr_lo, wdata,
        output rdata, touch
    );

endinterface

`default_nettype wire

// File: led_array.sv
// LED array with per-channel brightness and blink, PWM drive of the LED pins
`default_nettype none
`timescale 1ns/1ns

module led_array #(
    parameter int PWM_BITS   = 8,
    parameter int BLINK_BITS = 10
) (
    input  wire                          clock,
    input  wire                          rst,
    periph_if.periph                     bus,
    output logic [io_pkg::NUM_LEDS-1:0]  led_pins
);

    // One command word per LED, full 32 bits kept
    io_pkg::led_cmd_t cmd_q [io_pkg::NUM_LEDS];

    logic [PWM_BITS-1:0]          pwm_cnt;    // Free running
    logic [BLINK_BITS-1:0]        blink_cnt;  // Free running
    logic                         blink_on;   // Blink phase
    logic [io_pkg::LED_IDX_W-1:0] idx;
    logic                         in_range;
    logic                         wr_hit;
    logic                         rd_hit;

    // Scale 8-bit brightness to the PWM counter width
    // Narrow counters keep the top bits, wide ones pad below
    function automatic logic [PWM_BITS-1:0] pwm_level(input logic [7:0] brightness);
        logic [PWM_BITS+7:0] wide;
        wide = {brightness, {PWM_BITS{1'b0}}};
        return wide[PWM_BITS+7 -: PWM_BITS];
    endfunction

    // Register decode
    assign idx      = bus.addr_lo[io_pkg::LED_IDX_W-1:0];
    assign in_range = bus.addr_lo < io_pkg::NUM_LEDS;   // 0x12..0x1F unmapped
    assign wr_hit   = bus.sel && bus.wr && in_range;
    assign rd_hit   = bus.sel && bus.rd && in_range;

    // Command storage
    always_ff @(posedge clock) begin
        if (rst) begin
            for (int i = 0; i < io_pkg::NUM_LEDS; i++) begin
                cmd_q[i] <= '0;  // All LEDs dark
            end
        end else if (wr_hit) begin
            cmd_q[idx] <= bus.wdata.led;  // LED view of the word
        end
    end

    // PWM and blink timebase
    always_ff @(posedge clock) begin
        if (rst) begin
            pwm_cnt   <= '0;
            blink_cnt <= '0;
        end else begin
            pwm_cnt   <= pwm_cnt + 1'b1;
            blink_cnt <= blink_cnt + 1'b1;  // Wraps every 2**BLINK_BITS cycles
        end
    end

    assign blink_on = blink_cnt[BLINK_BITS-1];  // Top bit is the phase

    // Pin drive
    // Level strictly above counter, so max level gives 2**N-1 of 2**N
    always_comb begin
        for (int i = 0; i < io_pkg::NUM_LEDS; i++) begin
            led_pins[i] = (pwm_level(cmd_q[i].brightness) > pwm_cnt)
                          && (!cmd_q[i].blink || blink_on);
        end
    end

    // Readback of the stored word
    assign bus.rdata = rd_hit ? cmd_q[idx] : '0;
    assign bus.touch = '0;  // No touch sources here

endmodule

`default_nettype wire

// File: cap_sensor_array.sv
// Capacitive touch array that charges the pads, times their discharge and flags touches
`default_nettype none
`timescale 1ns/1ns

module cap_sensor_array #(
    parameter int SENSE_PERIOD  = 256,
    parameter int CHARGE_CYCLES = 16
) (
    input  wire                              clock,
    input  wire                              rst,
    periph_if.periph                         bus,
    input  wire [io_pkg::NUM_SENSORS-1:0]    capacitive_sensors_in,
    output logic                             capacitive_sensors_out
);

    localparam int PHASE_W = $clog2(SENSE_PERIOD);
    localparam int COUNT_W = $clog2(SENSE_PERIOD + 1);  // Holds a full period

    // Config register offset inside the sensor block
    localparam logic [io_pkg::ADDR_W-1:0] CFG_OFS = io_pkg::CFG_ADDR - io_pkg::SENSE_BASE;

    logic [io_pkg::NUM_SENSORS-1:0] pad_meta;   // First sync stage
    logic [io_pkg::NUM_SENSORS-1:0] pad_sync;   // Second sync stage

    logic [PHASE_W-1:0] phase_q;     // Cycle within the period
    logic [PHASE_W-1:0] phase_nx;
    logic               period_end;
    logic               charge_q;    // Pads being charged

    logic [COUNT_W-1:0]             count_q   [io_pkg::NUM_SENSORS];
    logic [COUNT_W-1:0]             reading_q [io_pkg::NUM_SENSORS];
    logic [io_pkg::NUM_SENSORS-1:0] touch_q;
    io_pkg::sense_cfg_t             cfg_q;

    logic                             cfg_sel;
    logic                             cnt_sel;
    logic [io_pkg::SENSE_IDX_W-1:0]   pad_idx;
    logic [io_pkg::DATA_W-1:0]        rd_word;

    // Pad inputs are asynchronous
    always_ff @(posedge clock) begin
        pad_meta <= capacitive_sensors_in;
        pad_sync <= pad_meta;
    end

    // Measurement sequencer
    assign period_end = phase_q == PHASE_W'(SENSE_PERIOD - 1);
    assign phase_nx   = period_end ? '0 : phase_q + 1'b1;

    always_ff @(posedge clock) begin
        if (rst) begin
            // Park on the last cycle so the first period after reset is whole
            phase_q  <= PHASE_W'(SENSE_PERIOD - 1);
            charge_q <= 1'b0;
        end else begin
            phase_q  <= phase_nx;
            charge_q <= phase_nx < CHARGE_CYCLES;  // Tracks phase_q one for one
        end
    end

    assign capacitive_sensors_out = charge_q;

    // Discharge timers, readings and touch flags
    always_ff @(posedge clock) begin
        if (rst) begin
            for (int i = 0; i < io_pkg::NUM_SENSORS; i++) begin
                count_q[i]   <= '0;
                reading_q[i] <= '0;
            end
            touch_q <= '0;
        end else if (period_end) begin
            for (int i = 0; i < io_pkg::NUM_SENSORS; i++) begin
                reading_q[i] <= count_q[i];                      // Latch result
                touch_q[i]   <= count_q[i] >= cfg_q.threshold;   // Longer discharge when touched
                count_q[i]   <= '0;                              // Fresh start
            end
        end else if (!charge_q) begin
            for (int i = 0; i < io_pkg::NUM_SENSORS; i++) begin
                if (pad_sync[i]) begin
                    count_q[i] <= count_q[i] + 1'b1;  // Pad still above threshold
                end
            end
        end
    end

    // Register decode
    assign cfg_sel = bus.addr_lo == CFG_OFS[io_pkg::ADDR_LO_W-1:0];
    assign cnt_sel = bus.addr_lo < io_pkg::NUM_SENSORS;
    assign pad_idx = bus.addr_lo[io_pkg::SENSE_IDX_W-1:0];

    // Config register, whole word kept for readback
    always_ff @(posedge clock) begin
        if (rst) begin
            cfg_q           <= '0;
            cfg_q.threshold <= io_pkg::RESET_THRESHOLD;
        end else if (bus.sel && bus.wr && cfg_sel) begin
            cfg_q <= bus.wdata.cfg;  // Sensor view of the word
        end
    end

    // Read mux
    always_comb begin
        rd_word = '0;
        if (bus.sel && bus.rd) begin
            if (cnt_sel) begin
                rd_word = {{(io_pkg::DATA_W - COUNT_W){1'b0}}, reading_q[pad_idx]};
            end else if (cfg_sel) begin
                rd_word = cfg_q;
            end
        end
    end

    assign bus.rdata = rd_word;
    assign bus.touch = touch_q;

endmodule

`default_nettype wire

// File: io_bridge.sv
// Register port bridge that routes accesses to the LED and sensor blocks and returns read data
`default_nettype none
`timescale 1ns/1ns

module io_bridge (
    input  wire                          clock,
    input  wire                          rst,
    input  wire [io_pkg::ADDR_W-1:0]     bus_addr,
    input  wire [io_pkg::DATA_W-1:0]     bus_wdata,
    input  wire                          bus_wr,
    input  wire                          bus_rd,
    output logic [io_pkg::DATA_W-1:0]    bus_rdata,
    output logic                         bus_rvalid,
    periph_if.host                       led_bus,
    periph_if.host                       sense_bus
);

    logic                      led_hit;    // LED command words
    logic                      cnt_hit;    // Pad counts
    logic                      cfg_hit;    // Sensor config
    logic                      touch_hit;  // Touch mask, served here
    logic [io_pkg::DATA_W-1:0] touch_word;
    logic [io_pkg::DATA_W-1:0] rd_word;

    // Address map compare
    assign led_hit   = (bus_addr >= io_pkg::LED_BASE)
                       && (bus_addr < io_pkg::LED_BASE + io_pkg::NUM_LEDS);
    assign cnt_hit   = (bus_addr >= io_pkg::SENSE_BASE)
                       && (bus_addr < io_pkg::SENSE_BASE + io_pkg::NUM_SENSORS);
    assign cfg_hit   = bus_addr == io_pkg::CFG_ADDR;
    assign touch_hit = bus_addr == io_pkg::TOUCH_ADDR;

    // LED block
    assign led_bus.sel     = led_hit;
    assign led_bus.wr      = bus_wr;
    assign led_bus.rd      = bus_rd;
    assign led_bus.addr_lo = bus_addr[io_pkg::ADDR_LO_W-1:0];  // Base is block aligned
    assign led_bus.wdata   = bus_wdata;

    // Sensor block
    assign sense_bus.sel     = cnt_hit || cfg_hit;
    assign sense_bus.wr      = bus_wr;
    assign sense_bus.rd      = bus_rd;
    assign sense_bus.addr_lo = bus_addr[io_pkg::ADDR_LO_W-1:0];
    assign sense_bus.wdata   = bus_wdata;

    assign touch_word = {{(io_pkg::DATA_W - io_pkg::NUM_SENSORS){1'b0}}, sense_bus.touch};

    // Read select, unmapped gives zero
    always_comb begin
        if (led_hit) begin
            rd_word = led_bus.rdata;
        end else if (cnt_hit || cfg_hit) begin
            rd_word = sense_bus.rdata;
        end else if (touch_hit) begin
            rd_word = touch_word;
        end else begin
            rd_word = '0;
        end
    end

    // One valid pulse per read strobe
    always_ff @(posedge clock) begin
        if (rst) begin
            bus_rvalid <= 1'b0;
        end else begin
            bus_rvalid <= bus_rd;
        end
    end

    // Read data holds until the next read
    always_ff @(posedge clock) begin
        if (bus_rd) begin
            bus_rdata <= rd_word;
        end
    end

endmodule

`default_nettype wire

// File: io_subsystem.sv
// Top level of the I/O subsystem, joining the register bridge, LED array and touch sensor array
`default_nettype none
`timescale 1ns/1ns

module io_subsystem #(
    parameter int PWM_BITS      = 8,    // PWM counter width
    parameter int BLINK_BITS    = 10,   // Blink counter width
    parameter int SENSE_PERIOD  = 256,  // Cycles per measurement
    parameter int CHARGE_CYCLES = 16    // Charge part of each measurement
) (
    input  wire                              clock,
    input  wire                              rst,
    // Register port
    input  wire [io_pkg::ADDR_W-1:0]         bus_addr,
    input  wire [io_pkg::DATA_W-1:0]         bus_wdata,
    input  wire                              bus_wr,
    input  wire                              bus_rd,
    output logic [io_pkg::DATA_W-1:0]        bus_rdata,
    output logic                             bus_rvalid,
    // LED array
    output logic [io_pkg::NUM_LEDS-1:0]      led_pins,
    // Touch pads
    input  wire [io_pkg::NUM_SENSORS-1:0]    capacitive_sensors_in,
    output logic                             capacitive_sensors_out
);

    periph_if led_bus ();
    periph_if sense_bus ();

    io_bridge bridge_i (
        .clock      (clock),
        .rst        (rst),
        .bus_addr   (bus_addr),
        .bus_wdata  (bus_wdata),
        .bus_wr     (bus_wr),
        .bus_rd     (bus_rd),
        .bus_rdata  (bus_rdata),
        .bus_rvalid (bus_rvalid),
        .led_bus    (led_bus.host),
        .sense_bus  (sense_bus.host)
    );

    led_array #(
        .PWM_BITS   (PWM_BITS),
        .BLINK_BITS (BLINK_BITS)
    ) led_i (
        .clock    (clock),
        .rst      (rst),
        .bus      (led_bus.periph),
        .led_pins (led_pins)
    );

    cap_sensor_array #(
        .SENSE_PERIOD  (SENSE_PERIOD),
        .CHARGE_CYCLES (CHARGE_CYCLES)
    ) sense_i (
        .clock                  (clock),
        .rst                    (rst),
        .bus                    (sense_bus.periph),
        .capacitive_sensors_in  (capacitive_sensors_in),
        .capacitive_sensors_out (capacitive_sensors_out)
    );

endmodule

`default_nettype wire

// File: io_subsystem_props.sv
// Concurrent checks on the I/O subsystem ports that the testbench binds into the top level
`default_nettype none
`timescale 1ns/1ns

module io_subsystem_props #(
    parameter int PWM_BITS      = 8,
    parameter int BLINK_BITS    = 10,
    parameter int SENSE_PERIOD  = 256,
    parameter int CHARGE_CYCLES = 16
) (
    input wire                           clock,
    input wire                           rst,
    input wire [io_pkg::ADDR_W-1:0]      bus_addr,
    input wire [io_pkg::DATA_W-1:0]      bus_wdata,
    input wire                           bus_wr,
    input wire                           bus_rd,
    input wire [io_pkg::DATA_W-1:0]      bus_rdata,
    input wire                           bus_rvalid,
    input wire [io_pkg::NUM_LEDS-1:0]    led_pins,
    input wire                           capacitive_sensors_out
);

    int error_count = 0;  // Failed assertions so far

    logic [31:0]                 cyc;         // Cycles since reset for PWM and blink phase
    io_pkg::led_cmd_t            shadow [io_pkg::NUM_LEDS];
    logic [io_pkg::NUM_LEDS-1:0] dark_mask;
    logic [io_pkg::NUM_LEDS-1:0] full_mask;   // Max brightness without blink
    logic [io_pkg::NUM_LEDS-1:0] blink_mask;
    int                          high_run;    // Consecutive charge cycles
    int                          low_run;     // Consecutive release cycles
    logic                        rose_seen;   // First charge phase has started
    logic                        mapped;

    always_ff @(posedge clock) begin
        if (rst) begin
            cyc <= '0;
            for (int i = 0; i < io_pkg::NUM_LEDS; i++) begin
                shadow[i] <= '0;
            end
        end else begin
            cyc <= cyc + 1;
            if (bus_wr && bus_addr < io_pkg::NUM_LEDS) begin
                shadow[bus_addr[io_pkg::LED_IDX_W-1:0]] <= bus_wdata;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < io_pkg::NUM_LEDS; i++) begin
            dark_mask[i]  = shadow[i].brightness == 8'h00;
            full_mask[i]  = shadow[i].brightness == 8'hff && !shadow[i].blink;
            blink_mask[i] = shadow[i].blink;
        end
    end

    // Run lengths of the charge drive
    always_ff @(posedge clock) begin
        if (rst) begin
            high_run  <= 0;
            low_run   <= 0;
            rose_seen <= 1'b0;
        end else if (capacitive_sensors_out) begin
            high_run  <= high_run + 1;
            low_run   <= 0;
            rose_seen <= 1'b1;
        end else begin
            low_run  <= low_run + 1;
            high_run <= 0;
        end
    end

    assign mapped = (bus_addr < io_pkg::LED_BASE + io_pkg::NUM_LEDS)
                    || (bus_addr >= io_pkg::SENSE_BASE
                        && bus_addr < io_pkg::SENSE_BASE + io_pkg::NUM_SENSORS)
                    || bus_addr == io_pkg::TOUCH_ADDR
                    || bus_addr == io_pkg::CFG_ADDR;

    a_reset_quiet: assert property (@(posedge clock)
        rst |=> (!bus_rvalid && !capacitive_sensors_out && led_pins == '0))
        else begin
            error_count++;
            $error("outputs not low after reset");
        end

    a_rvalid_follows: assert property (@(posedge clock) disable iff (rst)
        bus_rd |=> bus_rvalid)
        else begin
            error_count++;
            $error("bus_rvalid missing after bus_rd");
        end

    a_rvalid_single: assert property (@(posedge clock) disable iff (rst)
        !bus_rd |=> !bus_rvalid)
        else begin
            error_count++;
            $error("bus_rvalid without a read");
        end

    a_unmapped_zero: assert property (@(posedge clock) disable iff (rst)
        (bus_rd && !mapped) |=> bus_rdata == '0)
        else begin
            error_count++;
            $error("unmapped read returned data");
        end

    a_led_dark: assert property (@(posedge clock) disable iff (rst)
        (led_pins & dark_mask) == '0)
        else begin
            error_count++;
            $error("LED at brightness zero is lit");
        end

    // Lit on every PWM step but the last
    a_led_full: assert property (@(posedge clock) disable iff (rst)
        (led_pins & full_mask) == ((cyc[PWM_BITS-1:0] == '1) ? '0 : full_mask))
        else begin
            error_count++;
            $error("full brightness LED has wrong duty");
        end

    a_blink_gate: assert property (@(posedge clock) disable iff (rst)
        !cyc[BLINK_BITS-1] |-> (led_pins & blink_mask) == '0)
        else begin
            error_count++;
            $error("blinking LED lit in off phase");
        end

    a_charge_len: assert property (@(posedge clock) disable iff (rst)
        $fell(capacitive_sensors_out) |-> high_run == CHARGE_CYCLES)
        else begin
            error_count++;
            $error("charge phase has wrong length");
        end

    a_release_len: assert property (@(posedge clock) disable iff (rst)
        ($rose(capacitive_sensors_out) && rose_seen)
        |-> low_run == SENSE_PERIOD - CHARGE_CYCLES)
        else begin
            error_count++;
            $error("release phase has wrong length");
        end

endmodule

`default_nettype wire

// File: tb_io_subsystem.sv
// Testbench that plays the processor on the register port and models the touch pads
`default_nettype none
`timescale 1ns/1ns

module tb_io_subsystem;

    localparam int PWM_BITS      = 4;
    localparam int BLINK_BITS    = 6;
    localparam int SENSE_PERIOD  = 64;
    localparam int CHARGE_CYCLES = 8;
    localparam int WAIT_LIMIT    = 4 * SENSE_PERIOD;  // Cycles before a wait gives up

    logic                            clock;
    logic                            rst;
    logic [io_pkg::ADDR_W-1:0]       bus_addr;
    logic [io_pkg::DATA_W-1:0]       bus_wdata;
    logic                            bus_wr;
    logic                            bus_rd;
    logic [io_pkg::DATA_W-1:0]       bus_rdata;
    logic                            bus_rvalid;
    logic [io_pkg::NUM_LEDS-1:0]     led_pins;
    logic [io_pkg::NUM_SENSORS-1:0]  capacitive_sensors_in;
    logic                            capacitive_sensors_out;

    int          pad_delay [io_pkg::NUM_SENSORS];  // Discharge time per pad
    int          pad_left  [io_pkg::NUM_SENSORS];  // Cycles left in this discharge
    int          reading   [io_pkg::NUM_SENSORS];  // Last readback of each count
    logic [31:0] led_model [io_pkg::NUM_LEDS];     // Words written to the LED block

    io_subsystem #(
        .PWM_BITS      (PWM_BITS),
        .BLINK_BITS    (BLINK_BITS),
        .SENSE_PERIOD  (SENSE_PERIOD),
        .CHARGE_CYCLES (CHARGE_CYCLES)
    ) dut_i (
        .clock                  (clock),
        .rst                    (rst),
        .bus_addr               (bus_addr),
        .bus_wdata              (bus_wdata),
        .bus_wr                 (bus_wr),
        .bus_rd                 (bus_rd),
        .bus_rdata              (bus_rdata),
        .bus_rvalid             (bus_rvalid),
        .led_pins               (led_pins),
        .capacitive_sensors_in  (capacitive_sensors_in),
        .capacitive_sensors_out (capacitive_sensors_out)
    );

    bind io_subsystem io_subsystem_props #(
        .PWM_BITS      (PWM_BITS),
        .BLINK_BITS    (BLINK_BITS),
        .SENSE_PERIOD  (SENSE_PERIOD),
        .CHARGE_CYCLES (CHARGE_CYCLES)
    ) props_i (
        .clock                  (clock),
        .rst                    (rst),
        .bus_addr               (bus_addr),
        .bus_wdata              (bus_wdata),
        .bus_wr                 (bus_wr),
        .bus_rd                 (bus_rd),
        .bus_rdata              (bus_rdata),
        .bus_rvalid             (bus_rvalid),
        .led_pins               (led_pins),
        .capacitive_sensors_out (capacitive_sensors_out)
    );

    initial clock = 1'b0;
    always #5 clock = ~clock;  // 10 ns period

    // Pads charge while driven and stay high for their delay afterwards
    always @(posedge clock) begin
        #1;
        for (int i = 0; i < io_pkg::NUM_SENSORS; i++) begin
            if (capacitive_sensors_out) begin
                pad_left[i]              = pad_delay[i];
                capacitive_sensors_in[i] = 1'b1;
            end else begin
                capacitive_sensors_in[i] = pad_left[i] != 0;
                if (pad_left[i] != 0) begin
                    pad_left[i] = pad_left[i] - 1;
                end
            end
        end
    end

    // Stop at the first failed assertion
    always @(posedge clock) begin
        if (dut_i.props_i.error_count != 0) begin
            $display("Assertion failed at time %0t", $time);
            $display("=== FAIL ===");
            $fatal(1, "assertion failure");
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("FAIL t=%0t %s expected %h actual %h", $time, name, expected, actual);
            $display("=== FAIL ===");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic bus_write(input logic [11:0] addr, input logic [31:0] data);
        @(posedge clock);
        #1;
        bus_addr  = addr;
        bus_wdata = data;
        bus_wr    = 1'b1;
        @(posedge clock);
        #1;
        bus_wr = 1'b0;
    endtask

    task automatic bus_read(input logic [11:0] addr, output logic [31:0] data);
        int n;
        @(posedge clock);
        #1;
        bus_addr = addr;
        bus_rd   = 1'b1;
        @(posedge clock);
        #1;
        bus_rd = 1'b0;
        for (n = 0; n < 8 && !bus_rvalid; n++) begin  // Normally already valid
            @(posedge clock);
            #1;
        end
        if (!bus_rvalid) begin
            $display("Timed out waiting for read data from address %h", addr);
            $display("=== FAIL ===");
            $fatal(1, "read timeout");
        end
        data = bus_rdata;
    endtask

    // Start of the next charge phase
    task automatic wait_charge_start();
        logic prev;
        prev = capacitive_sensors_out;
        for (int n = 0; n < WAIT_LIMIT; n++) begin
            @(posedge clock);
            #1;
            if (!prev && capacitive_sensors_out) begin
                return;
            end
            prev = capacitive_sensors_out;
        end
        $display("Timed out waiting for the sensor charge phase to start");
        $display("=== FAIL ===");
        $fatal(1, "charge timeout");
    endtask

    task automatic read_counts();
        logic [31:0] data;
        for (int i = 0; i < io_pkg::NUM_SENSORS; i++) begin
            bus_read(io_pkg::SENSE_BASE + 12'(i), data);
            reading[i] = int'(data);
        end
    endtask

    initial begin
        logic [31:0] data;
        logic [31:0] cfg_word;
        logic [8:0]  exp_mask;
        int          thr;
        rst                   = 1'b1;
        bus_addr              = '0;
        bus_wdata             = '0;
        bus_wr                = 1'b0;
        bus_rd                = 1'b0;
        capacitive_sensors_in = '0;
        for (int i = 0; i < io_pkg::NUM_SENSORS; i++) begin
            pad_delay[i] = 0;
            pad_left[i]  = 0;
        end
        void'($urandom(17));
        repeat (16) @(posedge clock);
        #1;
        rst = 1'b0;

        // Quiet outputs and threshold out of reset
        check_value("bus_rvalid", 32'd0, 32'(bus_rvalid));
        check_value("capacitive_sensors_out", 32'd0, 32'(capacitive_sensors_out));
        check_value("led_pins", 32'd0, 32'(led_pins));
        bus_read(io_pkg::CFG_ADDR, data);
        check_value("bus_rdata", 32'(io_pkg::RESET_THRESHOLD), data);

        // Holes in the map read as zero
        bus_read(12'h012, data);
        check_value("bus_rdata", 32'd0, data);
        bus_read(12'h01f, data);
        check_value("bus_rdata", 32'd0, data);
        bus_read(12'h029, data);
        check_value("bus_rdata", 32'd0, data);
        bus_read(12'h032, data);
        check_value("bus_rdata", 32'd0, data);
        bus_read(12'hfff, data);
        check_value("bus_rdata", 32'd0, data);

        // Random LED words with a few forced to dark, full and full with blink
        for (int i = 0; i < io_pkg::NUM_LEDS; i++) begin
            led_model[i] = $urandom;
        end
        led_model[0][7:0] = 8'h00;
        led_model[1][8:0] = {1'b0, 8'hff};
        led_model[2][8:0] = {1'b1, 8'hff};
        for (int i = 0; i < io_pkg::NUM_LEDS; i++) begin
            bus_write(io_pkg::LED_BASE + 12'(i), led_model[i]);
        end
        for (int i = 0; i < io_pkg::NUM_LEDS; i++) begin
            bus_read(io_pkg::LED_BASE + 12'(i), data);
            check_value("bus_rdata", led_model[i], data);
        end

        // Whole config word survives including the spare bits
        cfg_word = $urandom;
        bus_write(io_pkg::CFG_ADDR, cfg_word);
        bus_read(io_pkg::CFG_ADDR, data);
        check_value("bus_rdata", cfg_word, data);
        repeat (3 << BLINK_BITS) @(posedge clock);  // Several blink periods of pin activity
        #1;

        // Random discharge times and one whole measurement
        for (int i = 0; i < io_pkg::NUM_SENSORS; i++) begin
            pad_delay[i] = $urandom % 51;
        end
        wait_charge_start();
        wait_charge_start();
        read_counts();
        for (int i = 0; i < io_pkg::NUM_SENSORS; i++) begin
            if (reading[i] < pad_delay[i] - 3 || reading[i] > pad_delay[i] + 3) begin
                check_value("bus_rdata", 32'(pad_delay[i]), 32'(reading[i]));
            end
        end

        // Threshold right at one pad's count and then just above it
        for (int k = 0; k < 2; k++) begin
            thr      = reading[4] + k;
            cfg_word = {16'($urandom), 16'(thr)};
            bus_write(io_pkg::CFG_ADDR, cfg_word);
            wait_charge_start();
            wait_charge_start();
            bus_read(io_pkg::TOUCH_ADDR, data);
            read_counts();
            for (int i = 0; i < io_pkg::NUM_SENSORS; i++) begin
                exp_mask[i] = reading[i] >= thr;
            end
            check_value("bus_rdata", 32'(exp_mask), data);
        end

        if (dut_i.props_i.error_count != 0) begin
            $display("Assertion failures seen: %0d", dut_i.props_i.error_count);
            $display("=== FAIL ===");
            $fatal(1, "assertion failure");
        end else begin
            $display("=== PASS ===");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: files.f
io_pkg.sv
periph_if.sv
led_array.sv
cap_sensor_array.sv
io_bridge.sv
io_subsystem.sv
io_subsystem_props.sv
tb_io_subsystem.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := tb_io_subsystem
FILELIST  := files.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
SRCS      := $(shell grep -v '^+' $(FILELIST))
PASS_MSG  := === PASS ===

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only if the pass message shows up in the output
run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qF -- "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
